//--- rv3n_cfg.svh
/*
 * rv3n core sizing
 * word width, register file size and chain depth shared by
 * every block of the core
 */
`ifndef RV3N_CFG_SVH
`define RV3N_CFG_SVH

// data path
`define RV3N_XLEN 32

// general registers
`define RV3N_REG_NUM 32
`define RV3N_RGBIT 5

// number of chain stages behind the issue unit
`define RV3N_CHAIN_LEN 4

`endif

//--- rv3n_pkg.sv
/*
 * rv3n shared types
 * ALU opcodes, the forwarding entry seen by the issue unit
 * and the ALU evaluation used by the chain stages
 */
`include "rv3n_cfg.svh"

package rv3n_pkg;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SLT = 3'd7
	} alu_op_t;

	// one link as the issue unit sees it
	typedef struct packed {
		logic                   valid;
		logic                   done;
		logic [`RV3N_RGBIT-1:0] rd;
		logic [`RV3N_XLEN-1:0]  result;
	} fwd_t;

	function automatic logic [`RV3N_XLEN-1:0] alu_eval(
		input alu_op_t               op,
		input logic [`RV3N_XLEN-1:0] a,
		input logic [`RV3N_XLEN-1:0] b
	);
		logic [`RV3N_XLEN-1:0] res;
		case (op)
			ALU_ADD: res = a + b;
			ALU_SUB: res = a - b;
			ALU_AND: res = a & b;
			ALU_OR:  res = a | b;
			ALU_XOR: res = a ^ b;
			// shift amount from operand 1
			ALU_SLL: res = a << b[4:0];
			ALU_SRL: res = a >> b[4:0];
			ALU_SLT: res = {{(`RV3N_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
			default: res = '0;
		endcase
		return res;
	endfunction

endpackage

//--- rv3n_chain_if.sv
/*
 * rv3n chain link
 * one package between two neighbours of the chain, plus the
 * common step and a read-only view for forwarding
 */
`include "rv3n_cfg.svh"

interface rv3n_chain_if;
	import rv3n_pkg::*;

	logic                   valid;
	logic                   done;
	alu_op_t                op;
	logic [`RV3N_RGBIT-1:0] rd;
	logic [`RV3N_XLEN-1:0]  opa;
	logic [`RV3N_XLEN-1:0]  opb;
	logic [`RV3N_XLEN-1:0]  result;
	// advance strobe shared by all links
	logic                   step;

	//------------------------------------------------------------
	// views
	//------------------------------------------------------------
	modport src (
		output valid, done, op, rd, opa, opb, result, step
	);

	modport dst (
		input valid, done, op, rd, opa, opb, result, step
	);

	modport lookup (
		input valid, done, rd, result
	);

endinterface

//--- rv3n_issue.sv
/*
 * rv3n issue unit
 * takes one pre-decoded ALU instruction per cycle, resolves its
 * operands from the register file or the chain, stalls one cycle
 * on an uncomputed producer and launches the package into link 0
 */
`include "rv3n_cfg.svh"

module rv3n_issue (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_req,
	input  rv3n_pkg::alu_op_t      i_op,
	input  logic [`RV3N_RGBIT-1:0] i_rd,
	input  logic [`RV3N_RGBIT-1:0] i_rs0,
	input  logic [`RV3N_RGBIT-1:0] i_rs1,
	input  logic                   i_use_imm,
	input  logic [`RV3N_XLEN-1:0]  i_imm,
	input  logic                   i_hold,
	output logic                   o_ready,
	input  rv3n_pkg::fwd_t         i_fwd [`RV3N_CHAIN_LEN:0],
	output logic [`RV3N_RGBIT-1:0] o_rs0_order,
	output logic [`RV3N_RGBIT-1:0] o_rs1_order,
	input  logic [`RV3N_XLEN-1:0]  i_rs0_data,
	input  logic [`RV3N_XLEN-1:0]  i_rs1_data,
	rv3n_chain_if.src              out
);
	import rv3n_pkg::*;

	logic                   run_q;
	logic                   step;
	logic                   accept;
	logic                   hazard;
	logic                   rs0_pend;
	logic                   rs1_pend;
	logic [`RV3N_XLEN-1:0]  rs0_val;
	logic [`RV3N_XLEN-1:0]  rs1_val;
	logic                   valid_q;
	alu_op_t                op_q;
	logic [`RV3N_RGBIT-1:0] rd_q;
	logic [`RV3N_XLEN-1:0]  opa_q;
	logic [`RV3N_XLEN-1:0]  opb_q;

	// youngest link wins, so scan from the last link down to link 0
	// msb of the result flags a producer that has not computed yet
	function automatic logic [`RV3N_XLEN:0] pick(
		input logic [`RV3N_RGBIT-1:0] idx,
		input logic [`RV3N_XLEN-1:0]  gsr_data,
		input fwd_t                   fwd [`RV3N_CHAIN_LEN:0]
	);
		logic                  pend;
		logic [`RV3N_XLEN-1:0] data;
		pend = 1'b0;
		data = gsr_data;
		for (int k = `RV3N_CHAIN_LEN; k >= 0; k--) begin
			if (fwd[k].valid && (fwd[k].rd == idx)) begin
				pend = !fwd[k].done;
				data = fwd[k].result;
			end
		end
		// x0
		if (idx == '0) begin
			pend = 1'b0;
			data = '0;
		end
		return {pend, data};
	endfunction

	//------------------------------------------------------------
	// operand resolve and hazard
	//------------------------------------------------------------
	assign o_rs0_order = i_rs0;
	assign o_rs1_order = i_rs1;

	assign {rs0_pend, rs0_val} = pick(i_rs0, i_rs0_data, i_fwd);
	assign {rs1_pend, rs1_val} = pick(i_rs1, i_rs1_data, i_fwd);

	// operand 1 is not read when the immediate replaces it
	assign hazard  = rs0_pend || (rs1_pend && !i_use_imm);
	assign step    = !i_hold;
	assign o_ready = run_q && step && !hazard;
	assign accept  = i_req && o_ready;

	//------------------------------------------------------------
	// link 0
	//------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			run_q   <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			// bubble when nothing is taken
			if (step) begin
				valid_q <= accept;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			op_q  <= i_op;
			rd_q  <= i_rd;
			opa_q <= rs0_val;
			opb_q <= i_use_imm ? i_imm : rs1_val;
		end
	end

	assign out.valid  = valid_q;
	assign out.done   = 1'b0;
	assign out.op     = op_q;
	assign out.rd     = rd_q;
	assign out.opa    = opa_q;
	assign out.opb    = opb_q;
	assign out.result = '0;
	assign out.step   = step;

	a_link0_hold: assert property (
		@(posedge i_clk) disable iff (i_rst)
		!out.step |=> $stable({out.valid, out.op, out.rd, out.opa, out.opb})
	) else $error("link 0 changed while the chain was held");

endmodule

//--- rv3n_stage_ch.sv
/*
 * rv3n chain stage
 * carries one package forward on each step and computes the
 * ALU result for a package that arrives without one
 */
`include "rv3n_cfg.svh"

module rv3n_stage_ch (
	input  logic      i_clk,
	input  logic      i_rst,
	rv3n_chain_if.dst in,
	rv3n_chain_if.src out
);
	import rv3n_pkg::*;

	logic                   valid_q;
	logic                   done_q;
	alu_op_t                op_q;
	logic [`RV3N_RGBIT-1:0] rd_q;
	logic [`RV3N_XLEN-1:0]  opa_q;
	logic [`RV3N_XLEN-1:0]  opb_q;
	logic [`RV3N_XLEN-1:0]  result_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			valid_q <= 1'b0;
			done_q  <= 1'b0;
		end else if (in.step) begin
			valid_q <= in.valid;
			// anything valid leaves this stage computed
			done_q  <= in.valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (in.step) begin
			op_q  <= in.op;
			rd_q  <= in.rd;
			opa_q <= in.opa;
			opb_q <= in.opb;
			if (in.valid && !in.done) begin
				result_q <= alu_eval(in.op, in.opa, in.opb);
			end else begin
				result_q <= in.result;
			end
		end
	end

	//------------------------------------------------------------
	// outgoing link apart from the step
	//------------------------------------------------------------
	assign out.valid  = valid_q;
	assign out.done   = done_q;
	assign out.op     = op_q;
	assign out.rd     = rd_q;
	assign out.opa    = opa_q;
	assign out.opb    = opb_q;
	assign out.result = result_q;

	a_out_done: assert property (
		@(posedge i_clk) disable iff (i_rst)
		out.valid |-> (out.done && (out.result == alu_eval(out.op, out.opa, out.opb)))
	) else $error("valid package left a stage without its result");

endmodule

//--- rv3n_gsr.sv
/*
 * rv3n general register file
 * two read ports for the issue unit, written from the last link
 * of the chain, which also drives the retirement outputs
 */
`include "rv3n_cfg.svh"

module rv3n_gsr (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic [`RV3N_RGBIT-1:0] i_rs0_order,
	input  logic [`RV3N_RGBIT-1:0] i_rs1_order,
	output logic [`RV3N_XLEN-1:0]  o_rs0_data,
	output logic [`RV3N_XLEN-1:0]  o_rs1_data,
	rv3n_chain_if.dst              last,
	output logic                   o_wb_valid,
	output logic [`RV3N_RGBIT-1:0] o_wb_rd,
	output logic [`RV3N_XLEN-1:0]  o_wb_data
);

	logic [`RV3N_XLEN-1:0] regs [`RV3N_REG_NUM];
	logic                  wr_en;

	// retire on a stepping edge, x0 stays untouched
	assign wr_en = last.step && last.valid && (last.rd != '0);

	//------------------------------------------------------------
	// storage
	//------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < `RV3N_REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[last.rd] <= last.result;
		end
	end

	// x0 reads zero since it is never written
	assign o_rs0_data = regs[i_rs0_order];
	assign o_rs1_data = regs[i_rs1_order];

	//------------------------------------------------------------
	// retirement view
	//------------------------------------------------------------
	assign o_wb_valid = last.valid;
	assign o_wb_rd    = last.rd;
	assign o_wb_data  = last.result;

	a_x0_zero: assert property (
		@(posedge i_clk) disable iff (i_rst)
		regs[0] == '0
	) else $error("register 0 was written");

endmodule

//--- rv3n_core_top.sv
/*
 * rv3n execution core
 * issue unit, a chain of identical stages advancing on one step,
 * and the register file draining the last link
 */
`include "rv3n_cfg.svh"

module rv3n_core_top (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_req,
	input  logic [2:0]             i_op,
	input  logic [`RV3N_RGBIT-1:0] i_rd,
	input  logic [`RV3N_RGBIT-1:0] i_rs0,
	input  logic [`RV3N_RGBIT-1:0] i_rs1,
	input  logic                   i_use_imm,
	input  logic [`RV3N_XLEN-1:0]  i_imm,
	input  logic                   i_hold,
	output logic                   o_ready,
	output logic                   o_wb_valid,
	output logic [`RV3N_RGBIT-1:0] o_wb_rd,
	output logic [`RV3N_XLEN-1:0]  o_wb_data
);
	import rv3n_pkg::*;

	alu_op_t                op_in;
	fwd_t                   fwd [`RV3N_CHAIN_LEN:0];
	logic [`RV3N_RGBIT-1:0] rs0_order;
	logic [`RV3N_RGBIT-1:0] rs1_order;
	logic [`RV3N_XLEN-1:0]  rs0_data;
	logic [`RV3N_XLEN-1:0]  rs1_data;

	genvar k;

	// link 0 from issue, link k+1 from stage k
	rv3n_chain_if u_link [`RV3N_CHAIN_LEN:0] ();

	assign op_in = alu_op_t'(i_op);

	//------------------------------------------------------------
	// issue
	//------------------------------------------------------------
	rv3n_issue u_issue (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_req       (i_req),
		.i_op        (op_in),
		.i_rd        (i_rd),
		.i_rs0       (i_rs0),
		.i_rs1       (i_rs1),
		.i_use_imm   (i_use_imm),
		.i_imm       (i_imm),
		.i_hold      (i_hold),
		.o_ready     (o_ready),
		.i_fwd       (fwd),
		.o_rs0_order (rs0_order),
		.o_rs1_order (rs1_order),
		.i_rs0_data  (rs0_data),
		.i_rs1_data  (rs1_data),
		.out         (u_link[0])
	);

	//------------------------------------------------------------
	// chain
	//------------------------------------------------------------
	generate
	for (k = 0; k < `RV3N_CHAIN_LEN; k++) begin : gen_stage_ch
		rv3n_stage_ch u_stage_ch (
			.i_clk (i_clk),
			.i_rst (i_rst),
			.in    (u_link[k]),
			.out   (u_link[k+1])
		);

		// common step
		assign u_link[k+1].step = u_link[0].step;
	end
	endgenerate

	// forwarding entries, youngest first
	generate
	for (k = 0; k <= `RV3N_CHAIN_LEN; k++) begin : gen_fwd
		assign fwd[k] = {u_link[k].valid, u_link[k].done, u_link[k].rd, u_link[k].result};
	end
	endgenerate

	//------------------------------------------------------------
	// register file and writeback
	//------------------------------------------------------------
	rv3n_gsr u_gsr (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_rs0_order (rs0_order),
		.i_rs1_order (rs1_order),
		.o_rs0_data  (rs0_data),
		.o_rs1_data  (rs1_data),
		.last        (u_link[`RV3N_CHAIN_LEN]),
		.o_wb_valid  (o_wb_valid),
		.o_wb_rd     (o_wb_rd),
		.o_wb_data   (o_wb_data)
	);

endmodule

//--- tb_rv3n.sv
/*
 * rv3n core testbench
 * drives pre-decoded ALU instructions into the core, keeps an
 * in-order register model and checks every retirement against it
 */
`include "rv3n_cfg.svh"

module tb_rv3n;
	timeunit 1ns;
	timeprecision 100ps;
	import rv3n_pkg::*;

	localparam int TIMEOUT = 200;
	localparam int QW = `RV3N_RGBIT + `RV3N_XLEN;

	logic                   clk;
	logic                   rst;
	logic                   req;
	logic [2:0]             op;
	logic [`RV3N_RGBIT-1:0] rd;
	logic [`RV3N_RGBIT-1:0] rs0;
	logic [`RV3N_RGBIT-1:0] rs1;
	logic                   use_imm;
	logic [`RV3N_XLEN-1:0]  imm;
	logic                   hold;
	logic                   ready;
	logic                   wb_valid;
	logic [`RV3N_RGBIT-1:0] wb_rd;
	logic [`RV3N_XLEN-1:0]  wb_data;

	// reference register model and expected retirements
	logic [`RV3N_XLEN-1:0]  model [`RV3N_REG_NUM];
	logic [QW-1:0]          exp_q [$];
	logic                   exp_valid;
	logic [`RV3N_RGBIT-1:0] exp_rd;
	logic [`RV3N_XLEN-1:0]  exp_data;
	logic [`RV3N_XLEN-1:0]  mod_a;
	logic [`RV3N_XLEN-1:0]  mod_b;
	logic [`RV3N_XLEN-1:0]  mod_res;

	int   seed;
	int   err_cnt;
	int   pass_cnt;
	int   fail_cnt;
	int   accepted_cnt;
	int   retired_cnt;
	logic timed_out;
	logic any_accepted;
	logic hold_en;
	logic lat_check;

	rv3n_core_top u_rv3n_core_top (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_req      (req),
		.i_op       (op),
		.i_rd       (rd),
		.i_rs0      (rs0),
		.i_rs1      (rs1),
		.i_use_imm  (use_imm),
		.i_imm      (imm),
		.i_hold     (hold),
		.o_ready    (ready),
		.o_wb_valid (wb_valid),
		.o_wb_rd    (wb_rd),
		.o_wb_data  (wb_data)
	);

	always #20 clk = ~clk;

	// random hold pattern while enabled
	always @(posedge clk) begin
		#2;
		if (hold_en) begin
			hold = (($random(seed) & 3) == 0);
		end else begin
			hold = 1'b0;
		end
	end

	//------------------------------------------------------------
	// model updated at acceptance in issue order
	//------------------------------------------------------------
	always @(negedge clk) begin
		if (rst) begin
			exp_valid = 1'b0;
		end else begin
			// queue head is what the next stepping edge must retire
			exp_valid = (exp_q.size() != 0);
			if (exp_valid) begin
				{exp_rd, exp_data} = exp_q[0];
			end
			if (wb_valid && !hold) begin
				retired_cnt++;
				if (exp_q.size() != 0) begin
					void'(exp_q.pop_front());
				end
			end
			if (req && ready) begin
				mod_a   = model[rs0];
				mod_b   = use_imm ? imm : model[rs1];
				mod_res = alu_eval(alu_op_t'(op), mod_a, mod_b);
				if (rd != '0) begin
					model[rd] = mod_res;
				end
				exp_q.push_back({rd, mod_res});
				accepted_cnt++;
				any_accepted = 1'b1;
			end
		end
	end

	//------------------------------------------------------------
	// checks
	//------------------------------------------------------------
	a_wb_expected: assert property (
		@(posedge clk) disable iff (rst)
		(wb_valid && !hold) |-> exp_valid
	) else begin
		err_cnt++;
		$display("a retirement to x%0d came with no instruction outstanding", $sampled(wb_rd));
	end

	a_wb_match: assert property (
		@(posedge clk) disable iff (rst)
		(wb_valid && !hold && exp_valid) |-> (wb_rd == exp_rd && wb_data == exp_data)
	) else begin
		err_cnt++;
		$display("Error: o_wb_rd 0x%h (expected 0x%h), o_wb_data 0x%h (expected 0x%h)",
			$sampled(wb_rd), $sampled(exp_rd), $sampled(wb_data), $sampled(exp_data));
	end

	a_hold_freeze: assert property (
		@(posedge clk) disable iff (rst)
		hold |=> $stable({wb_valid, wb_rd, wb_data})
	) else begin
		err_cnt++;
		$display("writeback outputs moved while the core was held");
	end

	a_hold_not_ready: assert property (
		@(posedge clk) disable iff (rst)
		hold |-> !ready
	) else begin
		err_cnt++;
		$display("core was ready while held");
	end

	a_idle_after_reset: assert property (
		@(posedge clk) disable iff (rst)
		!any_accepted |-> !wb_valid
	) else begin
		err_cnt++;
		$display("writeback went valid before any instruction was accepted");
	end

	a_latency: assert property (
		@(posedge clk) disable iff (rst)
		(lat_check && req && ready) |-> ##(`RV3N_CHAIN_LEN) !wb_valid ##1 wb_valid
	) else begin
		err_cnt++;
		$display("writeback of an isolated instruction did not show up at chain depth");
	end

	//------------------------------------------------------------
	// stimulus helpers
	//------------------------------------------------------------
	function automatic logic [`RV3N_XLEN-1:0] rand_word();
		return $random(seed);
	endfunction

	// enter just after a rising edge and leave just after the accepting edge
	task automatic send(
		input logic [2:0]             s_op,
		input logic [`RV3N_RGBIT-1:0] s_rd,
		input logic [`RV3N_RGBIT-1:0] s_rs0,
		input logic [`RV3N_RGBIT-1:0] s_rs1,
		input logic                   s_use_imm,
		input logic [`RV3N_XLEN-1:0]  s_imm
	);
		int   n;
		logic taken;
		if (timed_out) begin
			return;
		end
		req     = 1'b1;
		op      = s_op;
		rd      = s_rd;
		rs0     = s_rs0;
		rs1     = s_rs1;
		use_imm = s_use_imm;
		imm     = s_imm;
		n       = 0;
		taken   = 1'b0;
		while (!taken && n < TIMEOUT) begin
			@(negedge clk);
			taken = ready;
			@(posedge clk);
			#2;
			n++;
		end
		req = 1'b0;
		if (!taken) begin
			timed_out = 1'b1;
			$display("timeout: instruction writing x%0d was never accepted", s_rd);
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < TIMEOUT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (exp_q.size() != 0) begin
			timed_out = 1'b1;
			$display("timeout: %0d instructions never retired", exp_q.size());
		end
	endtask

	task automatic report_test(input string name, input int e0);
		if (err_cnt == e0 && !timed_out) begin
			pass_cnt++;
			$display("test %s: passed", name);
		end else begin
			fail_cnt++;
			$display("test %s: failed", name);
		end
	endtask

	//------------------------------------------------------------
	// tests
	//------------------------------------------------------------
	task automatic quiet_after_reset();
		int e0;
		e0 = err_cnt;
		// writeback must stay quiet while idle
		repeat (8) @(posedge clk);
		#2;
		send(ALU_ADD, 5'd3, 5'd1, 5'd2, 1'b0, '0);
		drain();
		report_test("reset", e0);
	endtask

	task automatic cover_opcodes();
		int                    e0;
		logic [`RV3N_XLEN-1:0] w;
		e0 = err_cnt;
		for (int r = 1; r < `RV3N_REG_NUM; r++) begin
			send(ALU_ADD, 5'(r), 5'd0, 5'd0, 1'b1, rand_word());
		end
		for (int k = 0; k < 8; k++) begin
			for (int j = 0; j < 4; j++) begin
				w = rand_word();
				send(3'(k), 5'(rand_word()), 5'(rand_word()), 5'(rand_word()), w[0],
					rand_word());
			end
		end
		drain();
		report_test("all_ops", e0);
	endtask

	task automatic dependent_chains();
		int                     e0;
		logic [`RV3N_RGBIT-1:0] prev;
		logic [`RV3N_RGBIT-1:0] nxt;
		e0 = err_cnt;
		// straight chain where each reads the one before
		prev = 5'd1;
		for (int k = 0; k < 8; k++) begin
			nxt = 5'(k + 2);
			send(3'(k), nxt, prev, prev, 1'(k), rand_word());
			prev = nxt;
		end
		// the producer sits one link deeper for each filler before its consumer
		for (int g = 0; g <= `RV3N_CHAIN_LEN + 1; g++) begin
			send(ALU_ADD, 5'd10, 5'd10, 5'd0, 1'b1, rand_word());
			for (int f = 0; f < g; f++) begin
				send(ALU_XOR, 5'(20 + f), 5'd0, 5'd0, 1'b1, rand_word());
			end
			send(3'(rand_word()), 5'd11, 5'd10, 5'd10, 1'b0, '0);
		end
		drain();
		report_test("dep_chain", e0);
	endtask

	task automatic write_x0();
		int e0;
		e0 = err_cnt;
		send(ALU_ADD, 5'd0, 5'd5, 5'd0, 1'b1, 32'h0000_1234);
		send(ALU_OR, 5'd6, 5'd0, 5'd0, 1'b0, '0);
		send(ALU_SUB, 5'd7, 5'd0, 5'd0, 1'b1, 32'h0000_0001);
		send(ALU_ADD, 5'd0, 5'd0, 5'd0, 1'b1, 32'hdead_beef);
		// x0 producer still in link 0 here
		send(ALU_ADD, 5'd8, 5'd0, 5'd3, 1'b0, '0);
		drain();
		report_test("x0", e0);
	endtask

	task automatic random_hold();
		int e0;
		int a0;
		int r0;
		e0 = err_cnt;
		a0 = accepted_cnt;
		r0 = retired_cnt;
		hold_en = 1'b1;
		// narrow register range for frequent dependencies
		for (int k = 0; k < 40; k++) begin
			send(3'(rand_word()), 5'(rand_word() & 7), 5'(rand_word() & 7),
				5'(rand_word() & 7), 1'(rand_word()), rand_word());
		end
		hold_en = 1'b0;
		drain();
		a_hold_count: assert (accepted_cnt - a0 == 40 && retired_cnt - r0 == 40) else begin
			err_cnt++;
			$display("hold stream accepted %0d and retired %0d instead of 40 each",
				accepted_cnt - a0, retired_cnt - r0);
		end
		report_test("hold", e0);
	endtask

	task automatic isolated_latency();
		int e0;
		e0 = err_cnt;
		drain();
		lat_check = 1'b1;
		send(ALU_XOR, 5'd12, 5'd12, 5'd0, 1'b1, rand_word());
		drain();
		lat_check = 1'b0;
		report_test("latency", e0);
	endtask

	//------------------------------------------------------------
	// main
	//------------------------------------------------------------
	initial begin
		seed         = 49;
		clk          = 1'b0;
		rst          = 1'b1;
		req          = 1'b0;
		op           = '0;
		rd           = '0;
		rs0          = '0;
		rs1          = '0;
		use_imm      = 1'b0;
		imm          = '0;
		hold         = 1'b0;
		err_cnt      = 0;
		pass_cnt     = 0;
		fail_cnt     = 0;
		accepted_cnt = 0;
		retired_cnt  = 0;
		timed_out    = 1'b0;
		any_accepted = 1'b0;
		hold_en      = 1'b0;
		lat_check    = 1'b0;
		exp_valid    = 1'b0;
		exp_rd       = '0;
		exp_data     = '0;
		for (int r = 0; r < `RV3N_REG_NUM; r++) begin
			model[r] = '0;
		end
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		quiet_after_reset();
		cover_opcodes();
		dependent_chains();
		write_x0();
		random_hold();
		isolated_latency();
		$display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+.
rv3n_pkg.sv
rv3n_chain_if.sv
rv3n_issue.sv
rv3n_stage_ch.sv
rv3n_gsr.sv
rv3n_core_top.sv
tb_rv3n.sv

//--- Makefile
# Verilator simulation of the rv3n core
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv3n
FLIST     = build.f
MDIR      = obj_dir
PASS_MSG  = >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)
	@out="$$(./$(MDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(MDIR)
